//--- besm_ctrl.sv
`timescale 1ns/100ps

module besm_ctrl #(
    parameter int GRP_W = 5                         // Group register bits
) (
    input  logic                        clk,
    input  logic                        reset,
    input  besm_pkg::uop_t              i_uop,      // Decoded microinstruction
    input  logic [besm_pkg::DATA_W-1:0] i_y,        // Y bus
    input  logic [3:0]                  i_instr_mod,// Instruction modifier field
    output logic [besm_pkg::DATA_W-1:0] o_d,        // D bus
    output logic                        o_cond      // Tested condition
);

    besm_pkg::mode_flags_t     flags;
    logic [GRP_W-1:0]          group;
    logic [besm_pkg::MR_W-1:0] ureg;
    logic [besm_pkg::MR_W-1:0] mr_read;
    logic                      mr_sel;

    mode_reg mode_reg_i (
        .clk     (clk),
        .reset   (reset),
        .i_y     (i_y),
        .i_ydst  (i_uop.ydst),
        .i_ffcnt (i_uop.ffcnt),
        .i_iomp  (i_uop.iomp),
        .i_ise   (i_uop.ise),
        .i_clrcd (i_uop.clrcd),
        .o_flags (flags)
    );

    modifier_mem #(.GRP_W(GRP_W)) modifier_mem_i (
        .clk         (clk),
        .reset       (reset),
        .i_y         (i_y),
        .i_ydst      (i_uop.ydst),
        .i_mnsa      (i_uop.mnsa),
        .i_modnm     (i_uop.modnm),
        .i_instr_mod (i_instr_mod),
        .i_csm       (i_uop.csm),
        .i_wem       (i_uop.wem),
        .i_mod       (i_uop.mod),
        .o_group     (group),
        .o_ureg      (ureg),
        .o_mr_read   (mr_read),
        .o_mr_sel    (mr_sel)
    );

    d_cond_select #(.GRP_W(GRP_W)) d_cond_select_i (
        .i_dsrc    (i_uop.dsrc),
        .i_cond    (i_uop.cond),
        .i_icc     (i_uop.icc),
        .i_flags   (flags),
        .i_group   (group),
        .i_ureg    (ureg),
        .i_mr_read (mr_read),
        .i_mr_sel  (mr_sel),
        .o_d       (o_d),
        .o_cond    (o_cond)
    );

endmodule

//--- besm_pkg.sv
package besm_pkg;

    // ----------------------------------------
    // Bus and register widths
    // ----------------------------------------
    localparam int DATA_W = 64;             // Y and D buses
    localparam int RR_W   = 32;             // Mode register
    localparam int MR_W   = 32;             // Modifier register
    localparam int MN_W   = 5;              // Modifier number, top half privileged

    // Mode word bit positions
    localparam int RR_NORMB  = 0;           // Normalization block
    localparam int RR_RNDB   = 1;           // Rounding block
    localparam int RR_GRP    = 2;           // Group field, bits 4..2
    localparam int RR_OVRIB  = 5;           // Overflow interrupt block
    localparam int RR_BNB    = 10;          // Range check block
    localparam int RR_OVRFTB = 11;          // Field overflow check block
    localparam int RR_DRG    = 12;          // Dispatcher mode
    localparam int RR_NOINTR = 17;          // Interrupt mask
    localparam int RR_CEMLRG = 19;          // Spare emulation bit
    localparam int RR_INTSTP = 21;          // Stop on interrupt
    localparam int RR_CB     = 27;          // Address changed by reg 16
    localparam int RR_RCB    = 28;          // Right command flag
    localparam int RR_JMP    = 29;          // Jump command flag

    // ----------------------------------------
    // Microinstruction encodings
    // ----------------------------------------
    typedef enum logic [3:0] {
        YDST_NONE  = 4'd0,
        YDST_MODGN = 4'd1,                  // Group register
        YDST_RR    = 4'd3,                  // Mode register
        YDST_UREG  = 4'd8                   // Effective address register
    } ydst_e;

    typedef enum logic [3:0] {
        DSRC_NONE  = 4'd0,
        DSRC_MODGN = 4'd1,                  // Group word, bit 10 set
        DSRC_RR    = 4'd3,
        DSRC_UREG  = 4'd8
    } dsrc_e;

    typedef enum logic [4:0] {
        FF_LOGGRP = 5'd1,
        FF_MULGRP = 5'd2,
        FF_ADDGRP = 5'd3,
        FF_SETC   = 5'd5,
        FF_CLRRCB = 5'd6,
        FF_SETRCB = 5'd7,
        FF_CLRJMP = 5'd8,
        FF_SETJMP = 5'd9,
        FF_SETEI  = 5'd10,                  // Clears the interrupt mask
        FF_CLREI  = 5'd11,                  // Sets the interrupt mask
        FF_CLRTR0 = 5'd12,
        FF_SETTR0 = 5'd13,
        FF_CLRTR1 = 5'd14,
        FF_SETTR1 = 5'd15,
        FF_CLRTKK = 5'd18,
        FF_SETTKK = 5'd19,
        FF_SETNR  = 5'd20,                  // Native mode
        FF_SETER  = 5'd22,                  // Emulation mode
        FF_CHTKK  = 5'd23                   // Toggle TKK
    } ffcnt_e;

    typedef enum logic [4:0] {
        COND_YES    = 5'd0,
        COND_NORMB  = 5'd1,
        COND_RNDB   = 5'd2,
        COND_OVRIB  = 5'd3,
        COND_BNB    = 5'd4,
        COND_OVRFTB = 5'd5,
        COND_DRG    = 5'd6,
        COND_EMLRG  = 5'd7,
        COND_RCB    = 5'd8,
        COND_CB     = 5'd9,
        COND_CEMLRG = 5'd10,
        COND_CT     = 5'd11,
        COND_TR1    = 5'd12,
        COND_INTSTP = 5'd13,
        COND_IR15   = 5'd14,
        COND_TKK    = 5'd15,
        COND_TR0    = 5'd22
    } cond_e;

    typedef enum logic [1:0] {
        MNSA_UREG = 2'd0,                   // UREG low bits
        MNSA_IRA  = 2'd1,                   // Instruction modifier field
        MNSA_MP   = 2'd3                    // Inverted microinstruction field
    } mnsa_e;

    // ----------------------------------------
    // Bundles
    // ----------------------------------------
    typedef struct packed {
        ydst_e           ydst;
        dsrc_e           dsrc;
        ffcnt_e          ffcnt;
        logic            iomp;              // Flag decoder off
        logic            ise;               // TKK into RCB
        logic            clrcd;             // Clear CB
        cond_e           cond;
        logic            icc;               // Condition polarity
        mnsa_e           mnsa;
        logic [MN_W-1:0] modnm;
        logic            csm;               // Modifier memory access
        logic            wem;               // Modifier memory write
        logic            mod;               // Privileged access
    } uop_t;

    typedef struct packed {
        logic [RR_W-1:0] rr;                // Mode word
        logic            tr0;
        logic            tr1;
        logic            tkk;
        logic            besm6_mode;
    } mode_flags_t;

endpackage

//--- d_cond_select.sv
`timescale 1ns/100ps

module d_cond_select #(
    parameter int GRP_W = 5                         // Group register bits
) (
    input  besm_pkg::dsrc_e             i_dsrc,     // D source
    input  besm_pkg::cond_e             i_cond,     // Tested condition
    input  logic                        i_icc,      // Condition polarity
    input  besm_pkg::mode_flags_t       i_flags,
    input  logic [GRP_W-1:0]            i_group,
    input  logic [besm_pkg::MR_W-1:0]   i_ureg,
    input  logic [besm_pkg::MR_W-1:0]   i_mr_read,
    input  logic                        i_mr_sel,   // Modifier read cycle
    output logic [besm_pkg::DATA_W-1:0] o_d,        // D bus
    output logic                        o_cond      // To sequencer
);

    localparam int DW = besm_pkg::DATA_W;

    logic [DW-1:0] grp_word;                        // Bit 10 flags the group word
    logic          cond_sel;

    // ----------------------------------------
    // D bus
    // ----------------------------------------
    always_comb begin
        grp_word             = '0;
        grp_word[10]         = 1'b1;
        grp_word[5 +: GRP_W] = i_group;
    end

    always_comb begin
        case (i_dsrc)
            besm_pkg::DSRC_MODGN: o_d = grp_word;
            besm_pkg::DSRC_RR:    o_d = DW'(i_flags.rr);
            besm_pkg::DSRC_UREG:  o_d = DW'(i_ureg);
            default:              o_d = i_mr_sel ? DW'(i_mr_read) : '0;
        endcase
    end

    // ----------------------------------------
    // Condition multiplexer
    // ----------------------------------------
    always_comb begin
        case (i_cond)
            besm_pkg::COND_NORMB:  cond_sel = i_flags.rr[besm_pkg::RR_NORMB];
            besm_pkg::COND_RNDB:   cond_sel = i_flags.rr[besm_pkg::RR_RNDB];
            besm_pkg::COND_OVRIB:  cond_sel = i_flags.rr[besm_pkg::RR_OVRIB];
            besm_pkg::COND_BNB:    cond_sel = i_flags.rr[besm_pkg::RR_BNB];
            besm_pkg::COND_OVRFTB: cond_sel = i_flags.rr[besm_pkg::RR_OVRFTB];
            besm_pkg::COND_DRG:    cond_sel = i_flags.rr[besm_pkg::RR_DRG];
            besm_pkg::COND_EMLRG:  cond_sel = i_flags.besm6_mode;
            besm_pkg::COND_RCB:    cond_sel = i_flags.rr[besm_pkg::RR_RCB];
            besm_pkg::COND_CB:     cond_sel = i_flags.rr[besm_pkg::RR_CB];
            besm_pkg::COND_CEMLRG: cond_sel = i_flags.rr[besm_pkg::RR_CEMLRG];
            besm_pkg::COND_TR1:    cond_sel = i_flags.tr1;
            besm_pkg::COND_INTSTP: cond_sel = i_flags.rr[besm_pkg::RR_INTSTP];
            besm_pkg::COND_TKK:    cond_sel = i_flags.tkk;
            besm_pkg::COND_TR0:    cond_sel = i_flags.tr0;
            default:               cond_sel = 1'b1;   // YES, CT, IR15 and spares
        endcase
    end

    assign o_cond = i_icc ? cond_sel : ~cond_sel;   // Low icc inverts

    always_comb begin
        a_dsrc_named : assert final (i_dsrc inside {besm_pkg::DSRC_NONE,
            besm_pkg::DSRC_MODGN, besm_pkg::DSRC_RR, besm_pkg::DSRC_UREG})
            else $error("d_cond_select: unnamed D source %0d", i_dsrc);
    end

endmodule

//--- mode_reg.sv
`timescale 1ns/100ps

module mode_reg (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [besm_pkg::DATA_W-1:0] i_y,        // Y bus
    input  besm_pkg::ydst_e             i_ydst,     // Y destination
    input  besm_pkg::ffcnt_e            i_ffcnt,    // Flag operation
    input  logic                        i_iomp,     // Flag decoder off
    input  logic                        i_ise,      // Copy TKK into RCB
    input  logic                        i_clrcd,    // Clear CB from D device
    output besm_pkg::mode_flags_t       o_flags
);

    logic [besm_pkg::RR_W-1:0] rr;                  // Mode word
    logic                      tr0;                 // Microprogram flag 0
    logic                      tr1;                 // Microprogram flag 1
    logic                      tkk;                 // Standardizer right half
    logic                      besm6_mode;          // Emulation mode

    // ----------------------------------------
    // Mode word and flag triggers
    // ----------------------------------------
    // Later assignments win, so flag ops override the Y load
    always_ff @(posedge clk) begin
        if (reset) begin
            rr         <= '0;
            tr0        <= 1'b0;
            tr1        <= 1'b0;
            tkk        <= 1'b0;
            besm6_mode <= 1'b0;
        end else begin
            if (i_ydst == besm_pkg::YDST_RR)
                rr <= i_y[besm_pkg::RR_W-1:0];      // Full word load
            if (!i_iomp) begin
                case (i_ffcnt)
                    besm_pkg::FF_LOGGRP: rr[besm_pkg::RR_GRP +: 3] <= 3'b001;
                    besm_pkg::FF_MULGRP: rr[besm_pkg::RR_GRP +: 3] <= 3'b010;
                    besm_pkg::FF_ADDGRP: rr[besm_pkg::RR_GRP +: 3] <= 3'b100;
                    besm_pkg::FF_SETC:   rr[besm_pkg::RR_CB] <= 1'b1;
                    besm_pkg::FF_CLRRCB: rr[besm_pkg::RR_RCB] <= 1'b0;
                    besm_pkg::FF_SETRCB: rr[besm_pkg::RR_RCB] <= 1'b1;
                    besm_pkg::FF_CLRJMP: rr[besm_pkg::RR_JMP] <= 1'b0;
                    besm_pkg::FF_SETJMP: rr[besm_pkg::RR_JMP] <= 1'b1;
                    besm_pkg::FF_SETEI:  rr[besm_pkg::RR_NOINTR] <= 1'b0;  // Enable ints
                    besm_pkg::FF_CLREI:  rr[besm_pkg::RR_NOINTR] <= 1'b1;  // Mask ints
                    besm_pkg::FF_CLRTR0: tr0 <= 1'b0;
                    besm_pkg::FF_SETTR0: tr0 <= 1'b1;
                    besm_pkg::FF_CLRTR1: tr1 <= 1'b0;
                    besm_pkg::FF_SETTR1: tr1 <= 1'b1;
                    besm_pkg::FF_CLRTKK: tkk <= 1'b0;
                    besm_pkg::FF_SETTKK: tkk <= 1'b1;
                    besm_pkg::FF_SETNR:  besm6_mode <= 1'b0;
                    besm_pkg::FF_SETER:  besm6_mode <= 1'b1;
                    besm_pkg::FF_CHTKK:  tkk <= ~tkk;   // Counting mode
                    default: ;                          // Timer, halt, int codes
                endcase
            end

            // CB clear path from the D device beats SETC
            if (i_clrcd)
                rr[besm_pkg::RR_CB] <= 1'b0;

            // RCB takes old TKK, ahead of CLRRCB/SETRCB
            if (i_ise)
                rr[besm_pkg::RR_RCB] <= tkk;
        end
    end

    assign o_flags.rr         = rr;
    assign o_flags.tr0        = tr0;
    assign o_flags.tr1        = tr1;
    assign o_flags.tkk        = tkk;
    assign o_flags.besm6_mode = besm6_mode;

    // Group code leaves exactly one group bit set
    a_grp_onehot : assert property (@(posedge clk) disable iff (reset)
        (!i_iomp && i_ffcnt inside {besm_pkg::FF_LOGGRP, besm_pkg::FF_MULGRP,
                                    besm_pkg::FF_ADDGRP})
        |=> $onehot(rr[besm_pkg::RR_GRP +: 3]))
        else $error("mode_reg: group field not one-hot after group code");

endmodule

//--- modifier_mem.sv
`timescale 1ns/100ps

module modifier_mem #(
    parameter int GRP_W = 5                         // Group register bits
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [besm_pkg::DATA_W-1:0] i_y,        // Y bus
    input  besm_pkg::ydst_e             i_ydst,     // Y destination
    input  besm_pkg::mnsa_e             i_mnsa,     // Number source
    input  logic [besm_pkg::MN_W-1:0]   i_modnm,    // Microinstruction number
    input  logic [3:0]                  i_instr_mod,// Instruction field
    input  logic                        i_csm,      // Memory access
    input  logic                        i_wem,      // Write enable
    input  logic                        i_mod,      // Privileged access
    output logic [GRP_W-1:0]            o_group,    // Group register
    output logic [besm_pkg::MR_W-1:0]   o_ureg,     // Effective address
    output logic [besm_pkg::MR_W-1:0]   o_mr_read,  // Modifier read data
    output logic                        o_mr_sel    // Read cycle
);

    localparam int ADDR_W = GRP_W + besm_pkg::MN_W;

    logic [besm_pkg::MR_W-1:0] mr_mem [2**ADDR_W];  // Group x number
    logic [besm_pkg::MN_W-1:0] mn;                  // Modifier number
    logic [ADDR_W-1:0]         addr;
    logic                      from_mp;             // Number from microcode
    logic                      priv_blk;            // Privileged, no MOD
    logic                      zero_blk;            // M0 from UREG/IRA
    logic                      mr_we;

    // ----------------------------------------
    // Group and effective-address registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_group <= '0;
            o_ureg  <= '0;
        end else begin
            if (i_ydst == besm_pkg::YDST_MODGN)
                o_group <= i_y[5 +: GRP_W];         // Y bits 9..5
            if (i_ydst == besm_pkg::YDST_UREG)
                o_ureg <= i_y[besm_pkg::MR_W-1:0];
        end
    end

    // ----------------------------------------
    // Number select and protection
    // ----------------------------------------
    always_comb begin
        case (i_mnsa)
            besm_pkg::MNSA_UREG: mn = o_ureg[besm_pkg::MN_W-1:0];
            besm_pkg::MNSA_IRA:  mn = {1'b0, i_instr_mod};
            besm_pkg::MNSA_MP:   mn = ~i_modnm;     // Stored inverted
            default:             mn = '0;           // Unused code
        endcase
    end

    assign from_mp  = (i_mnsa == besm_pkg::MNSA_MP);
    assign priv_blk = mn[besm_pkg::MN_W-1] & ~from_mp & ~i_mod;
    assign zero_blk = (mn == '0) & ~from_mp;
    assign addr     = {o_group, mn};
    assign mr_we    = i_csm & i_wem & ~priv_blk & ~zero_blk;

    assign o_mr_read = priv_blk ? '0 : mr_mem[addr];
    assign o_mr_sel  = i_csm & ~i_wem;

    always_ff @(posedge clk) begin
        if (mr_we)
            mr_mem[addr] <= i_y[besm_pkg::MR_W-1:0];
    end

    // No write enable on M0 reached from UREG or the instruction field
    a_m0_no_we : assert property (@(posedge clk) disable iff (reset)
        !(mr_we &&
          ((i_mnsa == besm_pkg::MNSA_UREG && o_ureg[besm_pkg::MN_W-1:0] == '0) ||
           (i_mnsa == besm_pkg::MNSA_IRA && i_instr_mod == '0))))
        else $error("modifier_mem: write enable on M0 from a non-MP source");

endmodule

//--- sim.f
+incdir+.
besm_pkg.sv
mode_reg.sv
modifier_mem.sv
d_cond_select.sv
besm_ctrl.sv
tb_besm_ctrl.sv

//--- tb_besm_vectors.svh
    localparam int N_ROWS = 53;

    // test, ydst, dsrc, ff, ctl, cond, icc, mnsa, modnm, mem, imod, y,
    // wr_slot, rd_slot, chk, exp_d, exp_cond
    row_t rows [N_ROWS] = '{
        // Mode word round-trip
        '{1, 0, 3, 0, 3'b000, 0, 0, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},  // Zero after reset
        '{1, 3, 0, 0, 3'b000, 0, 0, 0, 0, 3'b000, 0, 64'h123456789abcdef0, 0, 0, 1, 0, 0},
        '{1, 3, 3, 0, 3'b000, 0, 0, 0, 0, 3'b000, 0, 0, 0, 0, 1, 64'h9abcdef0, 0},
        '{1, 0, 3, 0, 3'b000, 0, 0, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},  // Cleared again
        // Group codes, then flag set/clear seen through cond
        '{2, 0, 3, 1, 3'b000, 0, 0, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},  // LOGGRP
        '{2, 0, 3, 2, 3'b000, 0, 0, 0, 0, 3'b000, 0, 0, 0, 0, 1, 64'h4, 0},
        '{2, 0, 3, 3, 3'b000, 0, 0, 0, 0, 3'b000, 0, 0, 0, 0, 1, 64'h8, 0},
        '{2, 0, 3, 13, 3'b000, 22, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 64'h10, 0},  // SETTR0
        '{2, 0, 0, 12, 3'b000, 22, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 1},
        '{2, 0, 0, 15, 3'b000, 22, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},   // SETTR1
        '{2, 0, 0, 14, 3'b000, 12, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 1},
        '{2, 0, 0, 19, 3'b000, 12, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},   // SETTKK
        '{2, 0, 0, 23, 3'b000, 15, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 1},   // Toggle to 0
        '{2, 0, 0, 23, 3'b000, 15, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},   // Toggle to 1
        '{2, 0, 0, 18, 3'b000, 15, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 1},
        '{2, 0, 0, 22, 3'b000, 15, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},   // SETER
        '{2, 0, 0, 20, 3'b000, 7, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 1},    // SETNR
        '{2, 0, 0, 22, 3'b100, 7, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},    // iomp blocks
        '{2, 0, 3, 1, 3'b100, 7, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 64'h10, 0},
        '{2, 0, 3, 0, 3'b000, 7, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 64'h10, 0},
        // CB and RCB priorities
        '{3, 0, 0, 5, 3'b001, 9, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},     // clrcd wins
        '{3, 0, 0, 5, 3'b000, 9, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},
        '{3, 0, 0, 7, 3'b010, 9, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 1},     // ise, TKK 0
        '{3, 0, 0, 19, 3'b000, 8, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},
        '{3, 0, 0, 6, 3'b010, 8, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},     // ise, TKK 1
        '{3, 3, 3, 5, 3'b000, 8, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 64'h18000010, 1},
        '{3, 0, 3, 0, 3'b000, 8, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 64'h08000000, 0},
        // Polarity of the tested condition
        '{4, 0, 0, 0, 3'b000, 0, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 1},
        '{4, 0, 0, 0, 3'b000, 0, 0, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},
        '{4, 0, 0, 0, 3'b000, 11, 1, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 1},    // CT defaults high
        '{4, 0, 0, 0, 3'b000, 11, 0, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},
        '{4, 0, 0, 0, 3'b000, 15, 0, 0, 0, 3'b000, 0, 0, 0, 0, 1, 0, 0},
        // Modifier memory through MP, IRA and UREG numbers
        '{5, 0, 0, 0, 3'b000, 0, 0, 3, 28, 3'b110, 0, 0, 1, 0, 1, 0, 0},    // M3, group 0
        '{5, 0, 0, 0, 3'b000, 0, 0, 3, 28, 3'b100, 0, 0, 0, 1, 1, 0, 0},
        '{5, 1, 1, 0, 3'b000, 0, 0, 0, 0, 3'b000, 0, 64'h40, 0, 0, 1, 64'h400, 0},
        '{5, 0, 1, 0, 3'b000, 0, 0, 1, 0, 3'b110, 5, 0, 2, 0, 1, 64'h440, 0},
        '{5, 0, 0, 0, 3'b000, 0, 0, 1, 0, 3'b100, 5, 0, 0, 2, 1, 0, 0},
        '{5, 8, 8, 0, 3'b000, 0, 0, 0, 0, 3'b000, 0, 64'h7, 0, 0, 1, 0, 0},
        '{5, 0, 8, 0, 3'b000, 0, 0, 0, 0, 3'b110, 0, 0, 3, 0, 1, 64'h7, 0},  // M7 via UREG
        '{5, 0, 0, 0, 3'b000, 0, 0, 0, 0, 3'b100, 0, 0, 0, 3, 1, 0, 0},
        '{5, 1, 0, 0, 3'b000, 0, 0, 0, 0, 3'b000, 0, 64'ha0, 0, 0, 1, 0, 0},  // Group 5
        '{5, 0, 0, 0, 3'b000, 0, 0, 3, 28, 3'b110, 0, 0, 4, 0, 1, 0, 0},
        '{5, 1, 0, 0, 3'b000, 0, 0, 3, 28, 3'b100, 0, 64'h40, 0, 4, 1, 0, 0},
        '{5, 0, 0, 0, 3'b000, 0, 0, 1, 0, 3'b100, 5, 0, 0, 2, 1, 0, 0},     // Group 2 kept
        // M0 and privileged numbers
        '{6, 0, 0, 0, 3'b000, 0, 0, 3, 31, 3'b110, 0, 0, 5, 0, 1, 0, 0},    // MP may write M0
        '{6, 8, 0, 0, 3'b000, 0, 0, 3, 31, 3'b100, 0, 0, 0, 5, 1, 0, 0},
        '{6, 0, 0, 0, 3'b000, 0, 0, 0, 0, 3'b110, 0, 64'hdeadbeef, 0, 0, 1, 0, 0},
        '{6, 8, 0, 0, 3'b000, 0, 0, 3, 31, 3'b100, 0, 64'h13, 0, 5, 1, 0, 0},
        '{6, 0, 0, 0, 3'b000, 0, 0, 0, 0, 3'b111, 0, 0, 6, 0, 1, 0, 0},     // M19 with mod
        '{6, 0, 0, 0, 3'b000, 0, 0, 0, 0, 3'b101, 0, 0, 0, 6, 1, 0, 0},
        '{6, 0, 0, 0, 3'b000, 0, 0, 0, 0, 3'b100, 0, 0, 0, 0, 1, 0, 0},     // Reads zero
        '{6, 0, 0, 0, 3'b000, 0, 0, 0, 0, 3'b110, 0, 64'h55555555, 0, 0, 1, 0, 0},
        '{6, 0, 0, 0, 3'b000, 0, 0, 0, 0, 3'b101, 0, 0, 0, 6, 1, 0, 0}
    };

//--- tb_besm_ctrl.sv
`timescale 1ns/100ps

module tb_besm_ctrl;

    localparam int GRP_W    = 5;                    // Group register bits
    localparam int CLK_HALF = 4;                    // 8 ns period

    // One table row per clock cycle
    typedef struct packed {
        logic [3:0]  test;                          // Behavior number
        logic [3:0]  ydst;
        logic [3:0]  dsrc;
        logic [4:0]  ff;                            // Flag operation code
        logic [2:0]  ctl;                           // iomp, ise, clrcd
        logic [4:0]  cond;
        logic        icc;
        logic [1:0]  mnsa;
        logic [4:0]  modnm;
        logic [2:0]  mem;                           // csm, wem, mod
        logic [3:0]  imod;                          // Instruction modifier field
        logic [63:0] y;
        logic [2:0]  wr_slot;                       // Random Y saved in model slot
        logic [2:0]  rd_slot;                       // Expected D taken from model slot
        logic        chk;
        logic [63:0] exp_d;
        logic        exp_cond;
    } row_t;

    `include "tb_besm_vectors.svh"

    localparam int CYCLE_LIMIT = 4 * N_ROWS + 20;

    logic                        clk;
    logic                        reset;
    besm_pkg::uop_t              uop;
    logic [besm_pkg::DATA_W-1:0] y;
    logic [3:0]                  instr_mod;
    logic [besm_pkg::DATA_W-1:0] d;
    logic                        cond;

    logic [besm_pkg::MR_W-1:0] model [8];           // Written modifier words
    integer seed;
    int     cycles = 0;
    int     checks;
    int     errors;
    int     test_checks;
    int     test_errors;

    besm_ctrl #(.GRP_W(GRP_W)) dut_i (
        .clk         (clk),
        .reset       (reset),
        .i_uop       (uop),
        .i_y         (y),
        .i_instr_mod (instr_mod),
        .o_d         (d),
        .o_cond      (cond)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // ----------------------------------------
    // Row decoding and reporting
    // ----------------------------------------
    function automatic besm_pkg::uop_t uop_from_row(input row_t r);
        besm_pkg::uop_t u;
        u.ydst  = besm_pkg::ydst_e'(r.ydst);
        u.dsrc  = besm_pkg::dsrc_e'(r.dsrc);
        u.ffcnt = besm_pkg::ffcnt_e'(r.ff);         // Zero is a no-op code
        u.iomp  = r.ctl[2];
        u.ise   = r.ctl[1];
        u.clrcd = r.ctl[0];
        u.cond  = besm_pkg::cond_e'(r.cond);
        u.icc   = r.icc;
        u.mnsa  = besm_pkg::mnsa_e'(r.mnsa);
        u.modnm = r.modnm;
        u.csm   = r.mem[2];
        u.wem   = r.mem[1];
        u.mod   = r.mem[0];
        return u;
    endfunction

    task close_test(input int num);
        $display("Test %0d finished: %0d checks, %0d errors", num, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // Watchdog on clock cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Table-driven stimulus and checks
    // ----------------------------------------
    initial begin
        row_t                        r;
        logic [besm_pkg::DATA_W-1:0] row_y;
        logic [besm_pkg::DATA_W-1:0] exp_d;
        int                          cur_test;

        seed        = 32'hf0427ce1;
        reset       = 1'b1;
        uop         = '0;
        y           = '0;
        instr_mod   = '0;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        cur_test    = rows[0].test;

        repeat (4) @(posedge clk);
        reset <= 1'b0;                              // First row shares this edge
        for (int i = 0; i < N_ROWS; i++) begin
            r = rows[i];
            if (r.test != cur_test) begin
                close_test(cur_test);
                cur_test = r.test;
            end
            row_y = r.y;
            if (r.wr_slot != 0) begin
                row_y = {$random(seed), $random(seed)};
                model[r.wr_slot] = row_y[besm_pkg::MR_W-1:0];   // Only low word stored
            end
            uop       <= uop_from_row(r);
            y         <= row_y;
            instr_mod <= r.imod;
            #(2 * CLK_HALF - 1);                    // Just before the next edge
            exp_d = r.exp_d;
            if (r.rd_slot != 0)
                exp_d = {32'h0, model[r.rd_slot]};
            if (r.chk) begin
                checks++;
                test_checks++;
                if (d !== exp_d) begin
                    $display("FAIL at %0t ns: row %0d o_d = %h, expected %h",
                             $time, i, d, exp_d);
                    errors++;
                    test_errors++;
                end
                if (cond !== r.exp_cond) begin
                    $display("FAIL at %0t ns: row %0d o_cond = %b, expected %b",
                             $time, i, cond, r.exp_cond);
                    errors++;
                    test_errors++;
                end
            end
            @(posedge clk);
        end
        close_test(cur_test);

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
